// ==== run_sim.sh ====
#!/bin/sh
# build the pcs csr testbench with verilator, run it, grade the log

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module pcs_csr_tb --Mdir "$build_dir" -o pcs_csr_sim -f src.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$build_dir/pcs_csr_sim" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the testbench prints its pass line only when every check held
if grep -qx "No errors" "$log"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1

// ==== source/control_bank.sv ====
`include "pcs_csr_settings.svh"
`default_nettype none
`timescale 1ns/10ps

module control_bank
  import pcs_csr_pkg::*;
(
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic                                  req_write,
  input  csr_sel_e                              req_sel,
  input  logic [`CSR_DATA_W-1:0]                req_data,
  output logic [`CSR_LANE_W-1:0]                lane_number,
  output logic [`CSR_LANES-1:0]                 tx_invpolarity,
  output logic [`CSR_LANES*`CSR_BOUNDARY_W-1:0] tx_bitslipboundaryselect,
  output logic [`CSR_LANES-1:0]                 rx_invpolarity,
  output logic [`CSR_LANES-1:0]                 rx_enapatternalign,
  output logic [`CSR_LANES-1:0]                 rx_bitreversalenable,
  output logic [`CSR_LANES-1:0]                 rx_bytereversalenable,
  output logic [`CSR_LANES-1:0]                 rx_bitslip,
  output logic [`CSR_LANES-1:0]                 rx_a1a2size
);

  localparam int BW = `CSR_BOUNDARY_W;

  ////////////////////////////////////////////////////////////////////////////
  // lane number and lane-indexed control registers
  ////////////////////////////////////////////////////////////////////////////
  // only the slice picked by lane_number takes a control write, so a lane
  // number past the last lane matches no slice and the write drops out
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      lane_number              <= '0;
      tx_invpolarity           <= '0;
      tx_bitslipboundaryselect <= '0;
      rx_invpolarity           <= '0;
      rx_enapatternalign       <= '0;
      rx_bitreversalenable     <= '0;
      rx_bytereversalenable    <= '0;
      rx_bitslip               <= '0;
      rx_a1a2size              <= '0;
    end else if (req_write) begin
      if (req_sel == sel_lane_group) begin
        lane_number <= req_data[`CSR_LANE_W-1:0];  // any value, read back as is
      end
      for (int l = 0; l < `CSR_LANES; l++) begin
        if (lane_number == `CSR_LANE_W'(l)) begin
          case (req_sel)
            sel_tx_control: begin
              tx_invpolarity[l]                 <= req_data[0];
              tx_bitslipboundaryselect[l*BW +: BW] <= req_data[BW:1];
            end
            sel_rx_control: begin
              rx_invpolarity[l] <= req_data[0];
            end
            sel_rx_wa_control: begin
              rx_enapatternalign[l]    <= req_data[0];
              rx_bitreversalenable[l]  <= req_data[1];
              rx_bytereversalenable[l] <= req_data[2];
              rx_bitslip[l]            <= req_data[3];
              rx_a1a2size[l]           <= req_data[4];  // same bit it reads on
            end
            default: ;  // status and lane group have no lane slice
          endcase
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/csr_access_decode.sv ====
`include "pcs_csr_settings.svh"
`default_nettype none
`timescale 1ns/10ps

module csr_access_decode
  import pcs_csr_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   write,      // one-cycle write level
  input  logic [`CSR_ADDR_W-1:0] address,
  input  logic [`CSR_DATA_W-1:0] writedata,
  output csr_sel_e               req_sel,
  output logic                   req_write,
  output logic [`CSR_DATA_W-1:0] req_data
);

  csr_sel_e sel_next;

  ////////////////////////////////////////////////////////////////////////////
  // address decode, the only address compare in the block
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    case (csr_addr_e'(address))
      addr_lane_group:    sel_next = sel_lane_group;
      addr_rx_status:     sel_next = sel_rx_status;
      addr_tx_status:     sel_next = sel_tx_status;
      addr_tx_control:    sel_next = sel_tx_control;
      addr_rx_control:    sel_next = sel_rx_control;
      addr_rx_wa_control: sel_next = sel_rx_wa_control;
      addr_rx_wa_status:  sel_next = sel_rx_wa_status;
      default:            sel_next = sel_unmapped;   // hole in the map
    endcase
  end

  // request stage, select, write level and data
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      req_sel   <= sel_lane_group;
      req_write <= 1'b0;
      req_data  <= '0;
    end else begin
      req_sel   <= sel_next;
      req_write <= write;
      req_data  <= writedata;
    end
  end

endmodule

`default_nettype wire

// ==== source/pcs_csr_pkg.sv ====
`include "pcs_csr_settings.svh"
`default_nettype none

package pcs_csr_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // register address map
  ////////////////////////////////////////////////////////////////////////////
  typedef enum logic [`CSR_ADDR_W-1:0] {
    addr_lane_group    = 'h00,  // lane (group) number for indirection
    addr_rx_status     = 'h01,  // ro, rx fifo error and boundary out
    addr_tx_status     = 'h02,  // ro, tx fifo error
    addr_tx_control    = 'h03,  // rw, invpolarity and bitslip boundary
    addr_rx_control    = 'h04,  // rw, invpolarity
    addr_rx_wa_control = 'h05,  // rw, word aligner controls
    addr_rx_wa_status  = 'h06   // ro, word aligner status
  } csr_addr_e;

  // decoded register select, carried down the access pipeline
  typedef enum logic [2:0] {
    sel_lane_group,
    sel_rx_status,
    sel_tx_status,
    sel_tx_control,
    sel_rx_control,
    sel_rx_wa_control,
    sel_rx_wa_status,
    sel_unmapped      // reads back all ones
  } csr_sel_e;

endpackage

`default_nettype wire

// ==== source/pcs_csr_settings.svh ====
`ifndef PCS_CSR_SETTINGS_SVH
`define PCS_CSR_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// register map sizing
////////////////////////////////////////////////////////////////////////////

`define CSR_LANES        4   // lanes served through the lane-select register
`define CSR_WORDS        2   // per-word status bits per lane (8b/10b status)
`define CSR_SYNC_STAGES  2   // depth of the status synchronizer

// field widths fixed by the register map
`define CSR_LANE_W       5   // lane number register
`define CSR_ADDR_W       8   // word address
`define CSR_DATA_W       32  // read and write data
`define CSR_BOUNDARY_W   5   // bitslip boundary, tx control and rx status

`endif

// ==== source/pcs_csr_top.sv ====
`include "pcs_csr_settings.svh"
`default_nettype none
`timescale 1ns/10ps

module pcs_csr_top
  import pcs_csr_pkg::*;
(
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic                                  write,
  input  logic [`CSR_ADDR_W-1:0]                address,
  input  logic [`CSR_DATA_W-1:0]                writedata,
  output logic [`CSR_DATA_W-1:0]                readdata,
  // transceiver status, async to clk
  input  logic [`CSR_LANES*`CSR_WORDS-1:0]      rx_patterndetect,
  input  logic [`CSR_LANES*`CSR_WORDS-1:0]      rx_syncstatus,
  input  logic [`CSR_LANES*`CSR_WORDS-1:0]      rx_errdetect,
  input  logic [`CSR_LANES*`CSR_WORDS-1:0]      rx_disperr,
  input  logic [`CSR_LANES*`CSR_WORDS-1:0]      rx_a1a2sizeout,
  input  logic [`CSR_LANES-1:0]                 rx_phase_comp_fifo_error,
  input  logic [`CSR_LANES-1:0]                 tx_phase_comp_fifo_error,
  input  logic [`CSR_LANES-1:0]                 rlv,
  input  logic [`CSR_LANES*`CSR_BOUNDARY_W-1:0] rx_bitslipboundaryselectout,
  // pcs controls, clk domain, synchronized by the pcs
  output logic [`CSR_LANES-1:0]                 tx_invpolarity,
  output logic [`CSR_LANES*`CSR_BOUNDARY_W-1:0] tx_bitslipboundaryselect,
  output logic [`CSR_LANES-1:0]                 rx_invpolarity,
  output logic [`CSR_LANES-1:0]                 rx_enapatternalign,
  output logic [`CSR_LANES-1:0]                 rx_bitreversalenable,
  output logic [`CSR_LANES-1:0]                 rx_bytereversalenable,
  output logic [`CSR_LANES-1:0]                 rx_bitslip,
  output logic [`CSR_LANES-1:0]                 rx_a1a2size
);

  ////////////////////////////////////////////////////////////////////////////
  // stage to stage wiring
  ////////////////////////////////////////////////////////////////////////////
  csr_sel_e                              req_sel;      // decode -> bank, mux
  logic                                  req_write;
  logic [`CSR_DATA_W-1:0]                req_data;
  logic [`CSR_LANE_W-1:0]                lane_number;  // bank -> mux
  logic [`CSR_LANES*`CSR_WORDS-1:0]      sync_rx_patterndetect;
  logic [`CSR_LANES*`CSR_WORDS-1:0]      sync_rx_syncstatus;
  logic [`CSR_LANES*`CSR_WORDS-1:0]      sync_rx_errdetect;
  logic [`CSR_LANES*`CSR_WORDS-1:0]      sync_rx_disperr;
  logic [`CSR_LANES*`CSR_WORDS-1:0]      sync_rx_a1a2sizeout;
  logic [`CSR_LANES-1:0]                 sync_rx_phase_comp_fifo_error;
  logic [`CSR_LANES-1:0]                 sync_tx_phase_comp_fifo_error;
  logic [`CSR_LANES-1:0]                 sync_rlv;
  logic [`CSR_LANES*`CSR_BOUNDARY_W-1:0] sync_rx_bitslipboundaryselectout;

  // port names match the wires one for one
  status_sync i_status_sync (.*);             // 2 cycles

  csr_access_decode i_csr_access_decode (.*); // edge 1, address in

  control_bank i_control_bank (.*);           // edge 2, write lands

  read_mux i_read_mux (.*);                   // edge 2, readdata out

endmodule

`default_nettype wire

// ==== source/read_mux.sv ====
`include "pcs_csr_settings.svh"
`default_nettype none
`timescale 1ns/10ps

module read_mux
  import pcs_csr_pkg::*;
(
  input  logic                                  clk,
  input  logic                                  reset,
  input  csr_sel_e                              req_sel,
  input  logic [`CSR_LANE_W-1:0]                lane_number,
  input  logic [`CSR_LANES-1:0]                 tx_invpolarity,
  input  logic [`CSR_LANES*`CSR_BOUNDARY_W-1:0] tx_bitslipboundaryselect,
  input  logic [`CSR_LANES-1:0]                 rx_invpolarity,
  input  logic [`CSR_LANES-1:0]                 rx_enapatternalign,
  input  logic [`CSR_LANES-1:0]                 rx_bitreversalenable,
  input  logic [`CSR_LANES-1:0]                 rx_bytereversalenable,
  input  logic [`CSR_LANES-1:0]                 rx_bitslip,
  input  logic [`CSR_LANES-1:0]                 rx_a1a2size,
  input  logic [`CSR_LANES*`CSR_WORDS-1:0]      sync_rx_patterndetect,
  input  logic [`CSR_LANES*`CSR_WORDS-1:0]      sync_rx_syncstatus,
  input  logic [`CSR_LANES*`CSR_WORDS-1:0]      sync_rx_errdetect,
  input  logic [`CSR_LANES*`CSR_WORDS-1:0]      sync_rx_disperr,
  input  logic [`CSR_LANES*`CSR_WORDS-1:0]      sync_rx_a1a2sizeout,
  input  logic [`CSR_LANES-1:0]                 sync_rx_phase_comp_fifo_error,
  input  logic [`CSR_LANES-1:0]                 sync_tx_phase_comp_fifo_error,
  input  logic [`CSR_LANES-1:0]                 sync_rlv,
  input  logic [`CSR_LANES*`CSR_BOUNDARY_W-1:0] sync_rx_bitslipboundaryselectout,
  output logic [`CSR_DATA_W-1:0]                readdata
);

  localparam int W  = `CSR_WORDS;
  localparam int BW = `CSR_BOUNDARY_W;

  // one lane's worth of every vector
  logic          l_tx_inv, l_rx_inv, l_pattalign, l_bitrev, l_byterev, l_bitslip;
  logic          l_a1a2size, l_rx_fifo_err, l_tx_fifo_err, l_rlv;
  logic [BW-1:0] l_tx_boundary, l_rx_boundary;
  logic [W-1:0]  l_patdet, l_syncstat, l_errdet, l_disperr, l_a1a2out;
  logic [`CSR_DATA_W-1:0] read_next;

  ////////////////////////////////////////////////////////////////////////////
  // lane select, all zero when lane_number is past the last lane
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    {l_tx_inv, l_rx_inv, l_pattalign, l_bitrev, l_byterev, l_bitslip} = '0;
    {l_a1a2size, l_rx_fifo_err, l_tx_fifo_err, l_rlv} = '0;
    {l_tx_boundary, l_rx_boundary} = '0;
    {l_patdet, l_syncstat, l_errdet, l_disperr, l_a1a2out} = '0;
    for (int l = 0; l < `CSR_LANES; l++) begin
      if (lane_number == `CSR_LANE_W'(l)) begin
        l_tx_inv      = tx_invpolarity[l];
        l_tx_boundary = tx_bitslipboundaryselect[l*BW +: BW];
        l_rx_inv      = rx_invpolarity[l];
        l_pattalign   = rx_enapatternalign[l];
        l_bitrev      = rx_bitreversalenable[l];
        l_byterev     = rx_bytereversalenable[l];
        l_bitslip     = rx_bitslip[l];
        l_a1a2size    = rx_a1a2size[l];
        l_rx_fifo_err = sync_rx_phase_comp_fifo_error[l];
        l_tx_fifo_err = sync_tx_phase_comp_fifo_error[l];
        l_rlv         = sync_rlv[l];
        l_rx_boundary = sync_rx_bitslipboundaryselectout[l*BW +: BW];
        l_patdet      = sync_rx_patterndetect[l*W +: W];
        l_syncstat    = sync_rx_syncstatus[l*W +: W];
        l_errdet      = sync_rx_errdetect[l*W +: W];
        l_disperr     = sync_rx_disperr[l*W +: W];
        l_a1a2out     = sync_rx_a1a2sizeout[l*W +: W];
      end
    end
  end

  // field packing per register, unused bits stay zero
  always_comb begin
    read_next = '0;
    case (req_sel)
      sel_lane_group:    read_next[`CSR_LANE_W-1:0] = lane_number;
      sel_rx_status:     read_next[BW:0] = {l_rx_boundary, l_rx_fifo_err};
      sel_tx_status:     read_next[0] = l_tx_fifo_err;
      sel_tx_control:    read_next[BW:0] = {l_tx_boundary, l_tx_inv};
      sel_rx_control:    read_next[0] = l_rx_inv;
      sel_rx_wa_control: read_next[4:0] = {l_a1a2size, l_bitslip, l_byterev,
                                           l_bitrev, l_pattalign};
      sel_rx_wa_status: begin
        read_next[3:0]   = 4'(l_errdet);     // word fields in low bits of nibble
        read_next[7:4]   = 4'(l_syncstat);
        read_next[11:8]  = 4'(l_disperr);
        read_next[15:12] = 4'(l_patdet);
        read_next[16]    = l_rlv;
        read_next[23:20] = 4'(l_a1a2out);
      end
      default:           read_next = '1;     // unmapped address
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) readdata <= '0;
    else       readdata <= read_next;
  end

endmodule

`default_nettype wire

// ==== source/status_sync.sv ====
`include "pcs_csr_settings.svh"
`default_nettype none
`timescale 1ns/10ps

module status_sync (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic [`CSR_LANES*`CSR_WORDS-1:0]      rx_patterndetect,
  input  logic [`CSR_LANES*`CSR_WORDS-1:0]      rx_syncstatus,
  input  logic [`CSR_LANES*`CSR_WORDS-1:0]      rx_errdetect,
  input  logic [`CSR_LANES*`CSR_WORDS-1:0]      rx_disperr,
  input  logic [`CSR_LANES*`CSR_WORDS-1:0]      rx_a1a2sizeout,
  input  logic [`CSR_LANES-1:0]                 rx_phase_comp_fifo_error,
  input  logic [`CSR_LANES-1:0]                 tx_phase_comp_fifo_error,
  input  logic [`CSR_LANES-1:0]                 rlv,
  input  logic [`CSR_LANES*`CSR_BOUNDARY_W-1:0] rx_bitslipboundaryselectout,
  output logic [`CSR_LANES*`CSR_WORDS-1:0]      sync_rx_patterndetect,
  output logic [`CSR_LANES*`CSR_WORDS-1:0]      sync_rx_syncstatus,
  output logic [`CSR_LANES*`CSR_WORDS-1:0]      sync_rx_errdetect,
  output logic [`CSR_LANES*`CSR_WORDS-1:0]      sync_rx_disperr,
  output logic [`CSR_LANES*`CSR_WORDS-1:0]      sync_rx_a1a2sizeout,
  output logic [`CSR_LANES-1:0]                 sync_rx_phase_comp_fifo_error,
  output logic [`CSR_LANES-1:0]                 sync_tx_phase_comp_fifo_error,
  output logic [`CSR_LANES-1:0]                 sync_rlv,
  output logic [`CSR_LANES*`CSR_BOUNDARY_W-1:0] sync_rx_bitslipboundaryselectout
);

  // all status bits share one chain, flattened into a single bus
  localparam int BUS_W = 5 * `CSR_LANES * `CSR_WORDS + 3 * `CSR_LANES
                         + `CSR_LANES * `CSR_BOUNDARY_W;

  logic [BUS_W-1:0] raw_bus;
  logic [BUS_W-1:0] stage_q [`CSR_SYNC_STAGES]; // [0] samples the async inputs

  assign raw_bus = {rx_patterndetect, rx_syncstatus, rx_errdetect, rx_disperr,
                    rx_a1a2sizeout, rx_phase_comp_fifo_error,
                    tx_phase_comp_fifo_error, rlv, rx_bitslipboundaryselectout};

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int s = 0; s < `CSR_SYNC_STAGES; s++) stage_q[s] <= '0;
    end else begin
      stage_q[0] <= raw_bus;                   // metastable stage
      for (int s = 1; s < `CSR_SYNC_STAGES; s++) begin
        stage_q[s] <= stage_q[s-1];
      end
    end
  end

  // last stage back out in the same field order
  assign {sync_rx_patterndetect, sync_rx_syncstatus, sync_rx_errdetect,
          sync_rx_disperr, sync_rx_a1a2sizeout, sync_rx_phase_comp_fifo_error,
          sync_tx_phase_comp_fifo_error, sync_rlv,
          sync_rx_bitslipboundaryselectout} = stage_q[`CSR_SYNC_STAGES-1];

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+source
source/pcs_csr_pkg.sv
source/status_sync.sv
source/csr_access_decode.sv
source/control_bank.sv
source/read_mux.sv
source/pcs_csr_top.sv
verification/pcs_csr_checker.sv
verification/pcs_csr_tb.sv

// ==== verification/pcs_csr_checker.sv ====
`include "pcs_csr_settings.svh"
`default_nettype none
`timescale 1ns/10ps

module pcs_csr_checker
  import pcs_csr_pkg::*;
(
  input logic                                  clk,
  input logic                                  reset,
  input logic [`CSR_ADDR_W-1:0]                address,
  input logic [`CSR_DATA_W-1:0]                readdata,
  input logic                                  req_write,    // decode stage
  input csr_sel_e                              req_sel,
  input logic [`CSR_LANE_W-1:0]                lane_number,
  input logic [`CSR_LANES-1:0]                 tx_invpolarity,
  input logic [`CSR_LANES*`CSR_BOUNDARY_W-1:0] tx_bitslipboundaryselect,
  input logic [`CSR_LANES-1:0]                 rx_invpolarity,
  input logic [`CSR_LANES-1:0]                 rx_enapatternalign,
  input logic [`CSR_LANES-1:0]                 rx_bitreversalenable,
  input logic [`CSR_LANES-1:0]                 rx_bytereversalenable,
  input logic [`CSR_LANES-1:0]                 rx_bitslip,
  input logic [`CSR_LANES-1:0]                 rx_a1a2size
);

  logic [7*`CSR_LANES+`CSR_LANES*`CSR_BOUNDARY_W-1:0] ctrl_all;  // every control output
  logic ctrl_sel;                                               // lane-indexed register

  assign ctrl_all = {tx_invpolarity, tx_bitslipboundaryselect, rx_invpolarity,
                     rx_enapatternalign, rx_bitreversalenable, rx_bytereversalenable,
                     rx_bitslip, rx_a1a2size};
  assign ctrl_sel = (req_sel == sel_tx_control) || (req_sel == sel_rx_control) ||
                    (req_sel == sel_rx_wa_control);

  ////////////////////////////////////////////////////////////////////////////
  // properties
  ////////////////////////////////////////////////////////////////////////////
  a_reset_clear: assert property (@(posedge clk)
    $fell(reset) |-> (ctrl_all == '0 && lane_number == '0))
    else $error("controls or lane number not cleared at reset release");

  // address outside the map, two edges later all ones
  a_unmapped_ones: assert property (@(posedge clk) disable iff (reset)
    ($past(address, 2) > 8'h06) |-> (readdata == '1))
    else $error("unmapped address did not read back all ones");

  // lane number past the last lane, control write drops out
  a_far_lane_write: assert property (@(posedge clk) disable iff (reset)
    (req_write && ctrl_sel && lane_number >= `CSR_LANE_W'(`CSR_LANES)) |=> $stable(ctrl_all))
    else $error("control write with out of range lane changed a control output");

endmodule

`default_nettype wire

// ==== verification/pcs_csr_tb.sv ====
`include "pcs_csr_settings.svh"
`default_nettype none
`timescale 1ns/10ps

module pcs_csr_tb;

  localparam int period = 10;
  localparam int lanes = `CSR_LANES;
  localparam int words = `CSR_WORDS;
  localparam int bw = `CSR_BOUNDARY_W;
  localparam int ctrl_w = 7 * lanes + lanes * bw;
  localparam int check_delay = 2 * period + period / 2;  // negedge after readdata lands
  localparam int hold = 5;                               // status hold before reads
  localparam int rounds = 4;
  // accesses of tests 1 to 6, then reset, drain per test and margin
  localparam int accesses = 7 + 11 * lanes + rounds * (1 + hold + 4 * lanes) + 8 + 34
                            + 2 * rounds * 4;
  localparam int watchdog_ns = (5 + accesses + 6 * 6 + 100) * period;

  logic clk;
  logic reset;
  logic write;
  logic [`CSR_ADDR_W-1:0] address;
  logic [`CSR_DATA_W-1:0] writedata;
  logic [`CSR_DATA_W-1:0] readdata;
  logic [lanes*words-1:0] rx_patterndetect, rx_syncstatus, rx_errdetect, rx_disperr;
  logic [lanes*words-1:0] rx_a1a2sizeout;
  logic [lanes-1:0] rx_phase_comp_fifo_error, tx_phase_comp_fifo_error, rlv;
  logic [lanes*bw-1:0] rx_bitslipboundaryselectout, tx_bitslipboundaryselect;
  logic [lanes-1:0] tx_invpolarity, rx_invpolarity, rx_enapatternalign;
  logic [lanes-1:0] rx_bitreversalenable, rx_bytereversalenable, rx_bitslip, rx_a1a2size;
  logic [ctrl_w-1:0] ctrl_now;

  // register model
  logic [`CSR_LANE_W-1:0] lane_m;
  logic [lanes-1:0] m_tx_inv;
  logic [lanes-1:0] m_rx_inv;
  logic [bw-1:0] m_tx_bnd [lanes];
  logic [4:0] m_wa [lanes];             // a1a2, bitslip, byte rev, bit rev, align

  // pending checks, oldest first
  longint due_q[$];
  bit kind_q[$];                        // 0 readdata, 1 control outputs
  logic [`CSR_ADDR_W-1:0] addr_q[$];
  logic [ctrl_w-1:0] exp_q[$];

  integer seed = 95;
  int errors = 0;
  int checks = 0;
  int tests = 0;

  pcs_csr_top i_dut (.*);
  bind pcs_csr_top pcs_csr_checker i_checker (.*);

  assign ctrl_now = {tx_invpolarity, tx_bitslipboundaryselect, rx_invpolarity,
                     rx_enapatternalign, rx_bitreversalenable, rx_bytereversalenable,
                     rx_bitslip, rx_a1a2size};

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////
  function automatic logic [31:0] rnd();
    return $random(seed);
  endfunction

  function automatic logic [`CSR_DATA_W-1:0] expected_read(input logic [7:0] a);
    logic [`CSR_DATA_W-1:0] d;
    bit in_range;
    int l;
    d = '0;
    l = int'(lane_m);
    in_range = (l < lanes);             // far lane reads zero fields
    case (a)
      8'h00: d[`CSR_LANE_W-1:0] = lane_m;
      8'h01: if (in_range) d[bw:0] = {rx_bitslipboundaryselectout[l*bw +: bw],
                                      rx_phase_comp_fifo_error[l]};
      8'h02: if (in_range) d[0] = tx_phase_comp_fifo_error[l];
      8'h03: if (in_range) d[bw:0] = {m_tx_bnd[l], m_tx_inv[l]};
      8'h04: if (in_range) d[0] = m_rx_inv[l];
      8'h05: if (in_range) d[4:0] = m_wa[l];
      8'h06: if (in_range) begin
        d[0 +: words]  = rx_errdetect[l*words +: words];     // one nibble per field
        d[4 +: words]  = rx_syncstatus[l*words +: words];
        d[8 +: words]  = rx_disperr[l*words +: words];
        d[12 +: words] = rx_patterndetect[l*words +: words];
        d[16]          = rlv[l];
        d[20 +: words] = rx_a1a2sizeout[l*words +: words];
      end
      default: d = '1;                  // hole in the map
    endcase
    return d;
  endfunction

  function automatic void model_write(input logic [7:0] a, input logic [31:0] data);
    int l;
    l = int'(lane_m);
    if (a == 8'h00) lane_m = data[`CSR_LANE_W-1:0];
    else if (l < lanes) begin
      case (a)
        8'h03: begin
          m_tx_inv[l] = data[0];
          m_tx_bnd[l] = data[bw:1];
        end
        8'h04: m_rx_inv[l] = data[0];
        8'h05: m_wa[l] = data[4:0];
        default: ;                      // status is read only
      endcase
    end
  endfunction

  function automatic logic [ctrl_w-1:0] control_image();
    logic [lanes*bw-1:0] bnd;
    logic [lanes-1:0] wa [5];
    for (int l = 0; l < lanes; l++) begin
      bnd[l*bw +: bw] = m_tx_bnd[l];
      for (int b = 0; b < 5; b++) wa[b][l] = m_wa[l][b];
    end
    return {m_tx_inv, bnd, m_rx_inv, wa[0], wa[1], wa[2], wa[3], wa[4]};
  endfunction

  function automatic void queue_check(input bit kind, input logic [7:0] a,
                                      input logic [ctrl_w-1:0] value, input longint due);
    kind_q.push_back(kind);
    addr_q.push_back(a);
    exp_q.push_back(value);
    due_q.push_back(due);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////
  task automatic access(input logic [7:0] a, input bit wr, input logic [31:0] data);
    @(posedge clk);
    address   <= a;
    write     <= wr;
    writedata <= data;
    if (wr) begin
      model_write(a, data);             // control slice lands two edges on
      queue_check(1'b1, a, control_image(), $time + check_delay);
    end else begin
      queue_check(1'b0, a, ctrl_w'(expected_read(a)), $time + check_delay);
    end
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      write <= 1'b0;
    end
  endtask

  task automatic apply_status();
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    r0 = rnd();
    r1 = rnd();
    r2 = rnd();
    @(posedge clk);
    write <= 1'b0;
    {rx_patterndetect, rx_syncstatus, rx_errdetect, rx_disperr} <= r0[4*lanes*words-1:0];
    {rx_a1a2sizeout, rx_phase_comp_fifo_error, tx_phase_comp_fifo_error, rlv}
      <= r1[lanes*words+3*lanes-1:0];
    rx_bitslipboundaryselectout <= r2[lanes*bw-1:0];
  endtask

  task automatic end_test(input string name, input int mark);
    idle(1);
    while (due_q.size() != 0) @(posedge clk);  // drain the read pipeline
    @(posedge clk);
    tests++;
    $display("test %0d %s: %0d mismatches", tests, name, errors - mark);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // compare, at the negedge after the result settles
  ////////////////////////////////////////////////////////////////////////////
  always @(negedge clk) begin
    bit kind;
    logic [7:0] a;
    logic [ctrl_w-1:0] value;
    while (due_q.size() != 0 && due_q[0] <= $time) begin
      kind  = kind_q.pop_front();
      a     = addr_q.pop_front();
      value = exp_q.pop_front();
      void'(due_q.pop_front());
      checks++;
      if (kind) begin
        assert (ctrl_now === value) else begin
          $display("Fail control outputs after write to %h: got %h expected %h",
                   a, ctrl_now, value);
          errors++;
        end
      end else begin
        assert (readdata === value[`CSR_DATA_W-1:0]) else begin
          $display("Fail readdata for address %h: got %h expected %h",
                   a, readdata, value[`CSR_DATA_W-1:0]);
          errors++;
        end
      end
    end
  end

  initial begin
    #(watchdog_ns);
    $display("timeout: run did not finish within %0d ns", watchdog_ns);
    $display("Errors found");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    logic [31:0] r;
    int mark;
    int a;
    reset     <= 1'b1;
    write     <= 1'b0;
    address   <= '0;
    writedata <= '0;
    {rx_patterndetect, rx_syncstatus, rx_errdetect, rx_disperr, rx_a1a2sizeout} <= '0;
    {rx_phase_comp_fifo_error, tx_phase_comp_fifo_error, rlv} <= '0;
    rx_bitslipboundaryselectout <= '0;
    lane_m   = '0;
    m_tx_inv = '0;
    m_rx_inv = '0;
    m_tx_bnd = '{default: '0};
    m_wa     = '{default: '0};
    repeat (5) @(posedge clk);
    reset <= 1'b0;

    mark = errors;                                 // 1 reset values
    queue_check(1'b1, 8'h00, control_image(), $time + period / 2);
    for (a = 0; a <= 6; a++) access(8'(a), 1'b0, '0);
    end_test("reset values", mark);

    mark = errors;                                 // 2 lane control writes
    for (int l = 0; l < lanes; l++) begin
      access(8'h00, 1'b1, 32'(l));
      for (a = 3; a <= 5; a++) begin
        access(8'(a), 1'b1, rnd());
        access(8'(a), 1'b0, '0);
      end
    end
    for (int l = 0; l < lanes; l++) begin          // other lanes kept their values
      access(8'h00, 1'b1, 32'(l));
      for (a = 3; a <= 5; a++) access(8'(a), 1'b0, '0);
    end
    end_test("lane control writes", mark);

    mark = errors;                                 // 3 status packing
    for (int n = 0; n < rounds; n++) begin
      apply_status();
      idle(hold);
      for (int l = 0; l < lanes; l++) begin
        access(8'h00, 1'b1, 32'(l));
        access(8'h01, 1'b0, '0);
        access(8'h02, 1'b0, '0);
        access(8'h06, 1'b0, '0);
      end
    end
    end_test("status packing", mark);

    mark = errors;                                 // 4 unmapped addresses
    access(8'h07, 1'b0, '0);
    access(8'hff, 1'b0, '0);
    repeat (6) begin
      r = rnd();
      access(r[7:0] | 8'h08, 1'b0, '0);
    end
    end_test("unmapped reads", mark);

    mark = errors;                                 // 5 lane number out of range
    for (int n = 0; n < 3; n++) begin
      r = rnd();
      if (n == 0) r = 32'(lanes);
      else if (n == 1) r = 32'h1f;
      else r = {27'd0, r[4:0] | 5'h04};
      access(8'h00, 1'b1, r);
      for (a = 3; a <= 5; a++) access(8'(a), 1'b1, rnd());
      for (a = 0; a <= 6; a++) access(8'(a), 1'b0, '0);
    end
    access(8'h00, 1'b1, '0);
    end_test("far lane number", mark);

    mark = errors;                                 // 6 write then read at once
    for (int n = 0; n < 2 * rounds; n++) begin
      r = rnd();
      access(8'h00, 1'b1, 32'(int'(r[7:0]) % lanes));
      access(8'h00, 1'b0, '0);
      a = 3 + int'(r[15:8]) % 3;
      access(8'(a), 1'b1, rnd());
      access(8'(a), 1'b0, '0);
    end
    end_test("back to back", mark);

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) $display("No errors");
    else $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire
